// File: Makefile
SIM := obj_dir/Vtb_rob_core

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): src.f $(wildcard design/*.sv test/*.sv test/*.svh)
	verilator --binary --timing --timescale 1ns/100ps --top-module tb_rob_core -f src.f

clean:
	rm -rf obj_dir

// File: design/dispatch_unit.sv
`timescale 1ns/100ps

module dispatch_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  rob_pkg::instr_t    in_instr,
    output logic               credit_return,
    input  logic               rob_full,
    input  rob_pkg::rob_tag_t  alloc_tag,
    output logic               dispatch,
    output rob_pkg::reg_addr_t dispatch_dst,
    input  logic               exec_ready,
    output logic               issue_valid,
    output rob_pkg::issue_t    issue,
    input  logic               flush
);
    import rob_pkg::*;

    instr_t                           q_mem [QUEUE_DEPTH];
    logic [$clog2(QUEUE_DEPTH)-1:0]   head_q;
    logic [$clog2(QUEUE_DEPTH)-1:0]   tail_q;
    credit_cnt_t                      count_q;
    logic                             push;
    logic                             pop;
    instr_t                           head_instr;

    // sender only drives in_valid while holding a credit, so no full check here
    assign push = in_valid && !flush;

    // pop needs a slot in the ROB and a free execution lane in the same cycle
    assign pop = (count_q != '0) && !rob_full && exec_ready && !flush;

    assign head_instr = q_mem[head_q];

    assign dispatch     = pop;
    assign dispatch_dst = head_instr.dst;
    assign issue_valid  = pop;

    always_comb begin
        issue.instr = head_instr;
        issue.tag   = alloc_tag;   // tag comes straight back from the ROB tail
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_mem[tail_q] <= in_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                tail_q <= tail_q + 1'b1;   // wraps at QUEUE_DEPTH
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + credit_cnt_t'(push) - credit_cnt_t'(pop);
        end
    end

    // one credit back per popped slot, a cycle after the pop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;
        end
    end

endmodule

// File: design/exec_cluster.sv
`timescale 1ns/100ps

module exec_cluster (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue_valid,
    input  rob_pkg::issue_t issue,
    output logic            exec_ready,
    output rob_pkg::cdb_t   cdb,
    input  logic            flush
);
    import rob_pkg::*;

    cdb_t  alu_q;
    cdb_t  alu_d;
    cdb_t  mul_q [MUL_STAGES];
    logic  mul_win;
    logic  alu_load;
    logic  mul_load;
    xlen_t product;

    // multiply lane has priority on the bus
    assign mul_win = mul_q[MUL_STAGES-1].valid;

    // ALU result blocked by a multiply, hold it and stall dispatch
    assign exec_ready = !(alu_q.valid && mul_win);

    assign alu_load = issue_valid && (issue.instr.op != OP_MUL);
    assign mul_load = issue_valid && (issue.instr.op == OP_MUL);
    assign product  = issue.instr.src_a * issue.instr.src_b;   // low 32 bits

    always_comb begin
        alu_d.valid      = alu_load;
        alu_d.tag        = issue.tag;
        alu_d.mispredict = 1'b0;
        case (issue.instr.op)
            OP_BR: begin
                alu_d.result     = issue.instr.src_a;
                alu_d.mispredict = (issue.instr.src_a != issue.instr.src_b);
            end
            default: begin
                alu_d.result = issue.instr.src_a + issue.instr.src_b;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            alu_q.valid <= 1'b0;
        end else if (exec_ready) begin
            alu_q <= alu_d;   // either drained this cycle or was empty
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int i = 0; i < MUL_STAGES; i++) begin
                mul_q[i].valid <= 1'b0;
            end
        end else begin
            mul_q[0].valid      <= mul_load;
            mul_q[0].tag        <= issue.tag;
            mul_q[0].result     <= product;
            mul_q[0].mispredict <= 1'b0;
            for (int i = 1; i < MUL_STAGES; i++) begin
                mul_q[i] <= mul_q[i-1];
            end
        end
    end

    assign cdb = mul_win ? mul_q[MUL_STAGES-1] : alu_q;

endmodule

// File: design/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dispatch,
    input  rob_pkg::reg_addr_t dispatch_dst,
    output rob_pkg::rob_tag_t  alloc_tag,
    output logic               rob_full,
    input  rob_pkg::cdb_t      cdb,
    output logic               wb_en,
    output rob_pkg::commit_t   wb,
    output logic               flush
);
    import rob_pkg::*;

    rob_entry_t rob_q [ROB_SIZE];
    rob_tag_t   head_q;
    rob_tag_t   tail_q;
    rob_cnt_t   count_q;
    rob_entry_t head_entry;
    logic       commit;

    assign head_entry = rob_q[head_q];

    assign alloc_tag = tail_q;
    assign rob_full  = (count_q == rob_cnt_t'(ROB_SIZE));   // count avoids head == tail ambiguity

    assign commit = head_entry.valid && head_entry.ready;
    assign wb_en  = commit;
    assign flush  = commit && head_entry.mispredict;

    always_comb begin
        wb.dst  = head_entry.dst;
        wb.data = head_entry.data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < ROB_SIZE; i++) begin
                rob_q[i].valid <= 1'b0;
                rob_q[i].ready <= 1'b0;
            end
        end else begin
            // new entry waits at the tail for its result
            if (dispatch) begin
                rob_q[tail_q].valid      <= 1'b1;
                rob_q[tail_q].ready      <= 1'b0;
                rob_q[tail_q].mispredict <= 1'b0;
                rob_q[tail_q].dst        <= dispatch_dst;
                tail_q                   <= tail_q + 1'b1;
            end

            if (cdb.valid) begin
                rob_q[cdb.tag].data       <= cdb.result;
                rob_q[cdb.tag].mispredict <= cdb.mispredict;
                rob_q[cdb.tag].ready      <= 1'b1;
            end

            // retire head in program order
            if (commit) begin
                rob_q[head_q].valid <= 1'b0;
                head_q              <= head_q + 1'b1;
            end

            count_q <= count_q + rob_cnt_t'(dispatch) - rob_cnt_t'(commit);
        end
    end

endmodule

// File: design/rob_core_top.sv
`timescale 1ns/100ps

module rob_core_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  rob_pkg::instr_t  in_instr,
    output logic             credit_return,
    output logic             wb_en,
    output rob_pkg::commit_t wb,
    output logic             flush
);
    import rob_pkg::*;

    logic      rob_full;
    rob_tag_t  alloc_tag;
    logic      dispatch;
    reg_addr_t dispatch_dst;
    logic      exec_ready;
    logic      issue_valid;
    issue_t    issue;
    cdb_t      cdb;

    dispatch_unit u_dispatch_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .credit_return (credit_return),
        .rob_full      (rob_full),
        .alloc_tag     (alloc_tag),
        .dispatch      (dispatch),
        .dispatch_dst  (dispatch_dst),
        .exec_ready    (exec_ready),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .flush         (flush)
    );

    exec_cluster u_exec_cluster (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .exec_ready  (exec_ready),
        .cdb         (cdb),
        .flush       (flush)
    );

    // flush originates here and clears the queue and both lanes
    reorder_buffer u_reorder_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .dispatch     (dispatch),
        .dispatch_dst (dispatch_dst),
        .alloc_tag    (alloc_tag),
        .rob_full     (rob_full),
        .cdb          (cdb),
        .wb_en        (wb_en),
        .wb           (wb),
        .flush        (flush)
    );

endmodule

// File: design/rob_pkg.sv
package rob_pkg;

    localparam int ROB_SIZE    = 8;
    localparam int QUEUE_DEPTH = 4;   // also the sender's starting credits
    localparam int MUL_STAGES  = 3;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  rob_tag_t;
    typedef logic [3:0]  rob_cnt_t;     // 0 .. ROB_SIZE
    typedef logic [2:0]  credit_cnt_t;  // 0 .. QUEUE_DEPTH

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_MUL = 2'd1,
        OP_BR  = 2'd2
    } op_t;

    typedef struct packed {
        op_t       op;
        reg_addr_t dst;
        xlen_t     src_a;
        xlen_t     src_b;
    } instr_t;

    typedef struct packed {
        instr_t   instr;
        rob_tag_t tag;
    } issue_t;

    // one result beat on the common data bus
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        xlen_t    result;
        logic     mispredict;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        logic      ready;       // result has come back from the bus
        logic      mispredict;
        reg_addr_t dst;
        xlen_t     data;
    } rob_entry_t;

    typedef struct packed {
        reg_addr_t dst;
        xlen_t     data;
    } commit_t;

endpackage

// File: src.f
+incdir+test
design/rob_pkg.sv
design/dispatch_unit.sv
design/exec_cluster.sv
design/reorder_buffer.sv
design/rob_core_top.sv
test/tb_rob_core.sv

// File: test/rob_ref_model.svh
`ifndef ROB_REF_MODEL_SVH
`define ROB_REF_MODEL_SVH

// one expected write-back beat
typedef struct packed {
    reg_addr_t dst;
    xlen_t     data;
    logic      mispredict;
} expect_t;

// expected result straight from the op rules
function automatic expect_t ref_result(input instr_t ins);
    expect_t     r;
    logic [63:0] wide;
    r.dst        = ins.dst;
    r.mispredict = 1'b0;
    case (ins.op)
        OP_ADD: begin
            r.data = ins.src_a + ins.src_b;
        end
        OP_MUL: begin
            wide   = {32'd0, ins.src_a} * {32'd0, ins.src_b};
            r.data = wide[31:0];   // only the low word is kept
        end
        OP_BR: begin
            r.data       = ins.src_a;
            r.mispredict = (ins.src_a != ins.src_b);
        end
        default: begin
            r.data = '0;
        end
    endcase
    return r;
endfunction

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end_in_failure();
    end
endtask

`endif

// File: test/tb_rob_core.sv
`timescale 1ns/100ps

module tb_rob_core;
    import rob_pkg::*;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    instr_t  in_instr;
    logic    credit_return;
    logic    wb_en;
    commit_t wb;
    logic    flush;

    integer seed        = 37;
    int     credits     = QUEUE_DEPTH;
    int     accepted    = 0;   // since the last flush
    int     returns     = 0;   // credit_return pulses since the last flush
    int     sent_total  = 0;
    int     flush_count = 0;
    int     cycle_count = 0;

    task automatic end_in_failure();
        $display("Test failures found");
        $fatal(1, "simulation stopped on the first error");
    endtask

    `include "rob_ref_model.svh"

    expect_t expected_q [$];
    expect_t head_beat;

    rob_core_top u_rob_core_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .credit_return (credit_return),
        .wb_en         (wb_en),
        .wb            (wb),
        .flush         (flush)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic build_instr(input op_t op, input logic equal_ops, output instr_t ins);
        ins.op    = op;
        ins.dst   = reg_addr_t'($random(seed));
        ins.src_a = $random(seed);
        ins.src_b = $random(seed);
        if (op == OP_BR && equal_ops) begin
            ins.src_b = ins.src_a;
        end else if (op == OP_BR && ins.src_b == ins.src_a) begin
            ins.src_b = ~ins.src_a;   // force a mispredict
        end
    endtask

    // called 10 ns after a rising edge, returns 10 ns after the next one
    task automatic send_instr(input instr_t ins);
        while (credits == 0) begin
            @(posedge clk);
            #10;
        end
        in_valid = 1'b1;
        in_instr = ins;
        credits--;
        accepted++;
        sent_total++;
        expected_q.push_back(ref_result(ins));
        @(posedge clk);
        #10;
        in_valid = 1'b0;
    endtask

    // op_kinds 1 gives adds only, 2 adds and muls, 3 adds in correct branches too
    task automatic send_stream(input int n, input int op_kinds);
        instr_t     ins;
        op_t        op;
        logic [1:0] pick;
        for (int i = 0; i < n; i++) begin
            pick = 2'($unsigned($random(seed)) % op_kinds);
            case (pick)
                2'd1:    op = OP_MUL;
                2'd2:    op = OP_BR;
                default: op = OP_ADD;
            endcase
            build_instr(op, 1'b1, ins);
            send_instr(ins);
            if (($random(seed) & 7) == 0) begin
                @(posedge clk);   // idle gap
                #10;
            end
        end
    endtask

    task automatic wait_for_drain();
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic wait_for_flush(input int seen);
        while (flush_count == seen) begin
            @(posedge clk);
            #10;
        end
    endtask

    // commit checker and credit bookkeeping on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (flush && !wb_en) begin
                $display("error: flush raised without a commit at %0t", $time);
                end_in_failure();
            end else if (wb_en) begin
                if (expected_q.size() == 0) begin
                    $display("error: commit at %0t with no instruction outstanding", $time);
                    end_in_failure();
                end else begin
                    head_beat = expected_q.pop_front();
                    check_value("commit dst", 32'(wb.dst), 32'(head_beat.dst));
                    check_value("commit data", wb.data, head_beat.data);
                    check_value("flush on commit", 32'(flush), 32'(head_beat.mispredict));
                end
            end
            if (flush) begin
                expected_q.delete();   // everything younger than the branch is gone
                credits  = QUEUE_DEPTH;
                accepted = 0;
                returns  = 0;
                flush_count++;
            end else if (credit_return) begin
                returns++;
                credits++;
            end
            if (credits > QUEUE_DEPTH) begin
                $display("error: sender credit count %0d out of range at %0t", credits, $time);
                end_in_failure();
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > 20 * sent_total + 200) begin
                $display("error: run timed out after %0d cycles", cycle_count);
                end_in_failure();
            end
        end
    end

    initial begin
        instr_t ins;
        int     flushes_before;
        in_valid = 1'b0;
        in_instr = '0;
        rst_n    = 1'b0;
        repeat (16) @(posedge clk);
        #10;
        check_value("wb_en after reset", 32'(wb_en), 32'd0);
        check_value("flush after reset", 32'(flush), 32'd0);
        check_value("credit_return after reset", 32'(credit_return), 32'd0);
        rst_n = 1'b1;

        send_stream(10, 1);   // ALU-only
        wait_for_drain();
        send_stream(16, 2);   // mixed latency with bus collisions
        wait_for_drain();
        send_stream(40, 3);   // long run that wraps the ROB tags
        wait_for_drain();

        repeat (3) begin
            build_instr(OP_BR, 1'b1, ins);
            send_instr(ins);
        end
        wait_for_drain();
        check_value("credit returns before flush", returns, accepted);

        flushes_before = flush_count;
        build_instr(OP_BR, 1'b0, ins);
        send_instr(ins);
        send_stream(3, 2);    // younger than the branch
        wait_for_flush(flushes_before);
        send_stream(8, 2);    // must be the next commits
        wait_for_drain();

        repeat (2) @(posedge clk);
        #10;
        check_value("credit returns after flush", returns, accepted);
        $display("All tests passed!");
        $finish;
    end

endmodule
